// ==== build.f ====
+incdir+sim
verilog/core_pkg.sv
verilog/hazard_if.sv
verilog/pipe_ctrl.sv
verilog/reg_file.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/result_stage.sv
verilog/mini_core.sv
sim/mini_core_tb.sv

// ==== sim/core_ref.svh ====
`ifndef CORE_REF_SVH
`define CORE_REF_SVH

// one instruction at a time, no pipeline
// memory depth follows dmem_depth of the including module
logic [data_w-1:0] model_regs [1 << reg_addr_w];
logic [data_w-1:0] model_mem [dmem_depth];

task automatic clear_model();
    for (int i = 0; i < (1 << reg_addr_w); i++) begin
        model_regs[i] = '0;
    end
endtask

task automatic step_model(
    input  instr_t                  ins,
    output logic                    beat,
    output logic [reg_addr_w-1:0]   rd,
    output logic [data_w-1:0]       value
);
    logic [data_w-1:0] a;
    logic [data_w-1:0] b;
    logic [data_w-1:0] addr;
    a     = model_regs[ins.rs];
    b     = model_regs[ins.rt];
    // rs plus sign-extended imm, shared by addi, ld and st
    addr  = a + {{(data_w - imm_w){ins.imm[imm_w-1]}}, ins.imm};
    value = '0;
    beat  = (ins.rd != '0);
    case (ins.opcode)
        op_add:  value = a + b;
        op_sub:  value = a - b;
        op_and:  value = a & b;
        op_xor:  value = a ^ b;
        op_addi: value = addr;
        op_mul:  value = a * b;
        op_ld:   value = model_mem[addr % dmem_depth];
        op_st: begin
            model_mem[addr % dmem_depth] = b;
            beat = 1'b0;
        end
        default: beat = 1'b0;
    endcase
    if (beat) begin
        model_regs[ins.rd] = value;
    end
    rd = ins.rd;
endtask

`endif

// ==== sim/mini_core_tb.sv ====
`timescale 1ns/1ps

module mini_core_tb
    import core_pkg::*;
();

    localparam int in_credits  = 2;
    localparam int out_credits = 4;
    localparam int mul_cycles  = 4;
    localparam int dmem_depth  = 64;
    localparam int n_instr     = 200;
    // about 5 cycles per instruction with the slowest credit return, four times over
    localparam int cycle_limit = n_instr * 5 * 4;

    typedef struct {
        logic [reg_addr_w-1:0]  rd;
        logic [data_w-1:0]      data;
    } beat_t;

    logic                   clk;
    logic                   rst;
    logic                   instr_valid;
    instr_t                 instr;
    logic                   instr_credit;
    logic                   res_valid;
    logic [reg_addr_w-1:0]  res_rd;
    logic [data_w-1:0]      res_data;
    logic                   res_credit;

    int                     seed = 72;
    int                     cycles = 0;
    int                     sent = 0;
    int                     credits_back = 0;
    int                     room = out_credits;
    int                     owed = 0;
    beat_t                  exp_q [$];
    logic                   exp_have = 1'b0;
    logic [reg_addr_w-1:0]  exp_rd = '0;
    logic [data_w-1:0]      exp_data = '0;

    `include "core_ref.svh"

    mini_core #(
        .in_credits(in_credits), .out_credits(out_credits),
        .mul_cycles(mul_cycles), .dmem_depth(dmem_depth)
    ) dut_i (
        .clk(clk), .rst(rst),
        .instr_valid(instr_valid), .instr(instr), .instr_credit(instr_credit),
        .res_valid(res_valid), .res_rd(res_rd), .res_data(res_data),
        .res_credit(res_credit)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        stop_with_failure($sformatf("MISMATCH at %0t: %s expected 0x%0h, got 0x%0h",
                                    $time, name, expected, actual));
    endtask

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic int pick_credit_delay();
        // now and then the consumer holds credits for a long stretch
        if (rand_below(10) == 0) return 20 + rand_below(16);
        return rand_below(4);
    endfunction

    task refresh_expected();
        exp_have = (exp_q.size() != 0);
        if (exp_have) begin
            exp_rd   = exp_q[0].rd;
            exp_data = exp_q[0].data;
        end
    endtask

    function automatic instr_t encode(opcode_e op, int rd, int rs, int rt, int imm);
        instr_t ins;
        ins.opcode = op;
        ins.rd     = reg_addr_w'(rd);
        ins.rs     = reg_addr_w'(rs);
        ins.rt     = reg_addr_w'(rt);
        ins.imm    = imm_w'(imm);
        return ins;
    endfunction

    function automatic instr_t random_instr();
        int     pick;
        opcode_e op;
        pick = rand_below(20);
        if (pick < 1) op = op_nop;
        else if (pick < 4) op = op_add;
        else if (pick < 6) op = op_sub;
        else if (pick < 8) op = op_and;
        else if (pick < 10) op = op_xor;
        else if (pick < 13) op = op_addi;
        else if (pick < 15) op = op_mul;
        else if (pick < 18) op = op_ld;
        else op = op_st;
        // memory traffic stays on the 8 words written at start
        if (op == op_ld || op == op_st) begin
            return encode(op, rand_below(8), 0, rand_below(8), rand_below(8));
        end
        return encode(op, rand_below(8), rand_below(8), rand_below(8), rand_below(256));
    endfunction

    task automatic send_instr(input instr_t ins);
        int                     gap;
        logic                   beat;
        logic [reg_addr_w-1:0]  rd;
        logic [data_w-1:0]      value;
        gap = (rand_below(4) != 0) ? 0 : 1 + rand_below(3);
        repeat (gap) begin
            @(posedge clk);
            #1;
            instr_valid = 1'b0;
        end
        @(posedge clk);
        #1;
        while (in_credits - sent + credits_back <= 0) begin
            instr_valid = 1'b0;
            @(posedge clk);
            #1;
        end
        instr_valid = 1'b1;
        instr       = ins;
        sent++;
        step_model(ins, beat, rd, value);
        if (beat) begin
            exp_q.push_back('{rd, value});
            refresh_expected();
        end
    endtask

    always @(posedge clk) begin : track_ports
        if (!rst) begin
            if (instr_credit) begin
                credits_back++;
            end
            if (res_credit) begin
                room++;
            end
            if (res_valid) begin
                room--;
                owed++;
                if (exp_q.size() != 0) begin
                    exp_q.delete(0);
                end
                refresh_expected();
            end
        end
    end

    always @(posedge clk) begin : watchdog
        cycles++;
        if (cycles >= cycle_limit) begin
            stop_with_failure($sformatf("timeout after %0d cycles, %0d of %0d sent, %0d pending",
                                        cycles, sent, n_instr, exp_q.size()));
        end
    end

    a_beat_expected: assert property (
        @(posedge clk) disable iff (rst)
        res_valid |-> exp_have
    ) else stop_with_failure("result beat arrived with no instruction expecting one");

    a_beat_rd: assert property (
        @(posedge clk) disable iff (rst)
        (res_valid && exp_have) |-> (res_rd === exp_rd)
    ) else report_mismatch("res_rd", 32'($sampled(exp_rd)), 32'($sampled(res_rd)));

    a_beat_data: assert property (
        @(posedge clk) disable iff (rst)
        (res_valid && exp_have) |-> (res_data === exp_data)
    ) else report_mismatch("res_data", 32'($sampled(exp_data)), 32'($sampled(res_data)));

    a_beat_credit: assert property (
        @(posedge clk) disable iff (rst)
        res_valid |-> (room > 0)
    ) else stop_with_failure("result beat sent without a granted credit");

    a_credit_owed: assert property (
        @(posedge clk) disable iff (rst)
        instr_credit |-> (sent > credits_back)
    ) else stop_with_failure("instruction credit returned with nothing outstanding");

    a_quiet_after_reset: assert property (
        @(posedge clk) disable iff (rst)
        (sent == 0) |-> (!res_valid && !instr_credit)
    ) else stop_with_failure("output activity before any instruction was sent");

    initial begin : credit_return
        int delay;
        res_credit = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            res_credit = 1'b0;
            if (owed > 0) begin
                delay = pick_credit_delay();
                repeat (delay) begin
                    @(posedge clk);
                    #1;
                end
                res_credit = 1'b1;
                owed--;
            end
        end
    end

    initial begin : stimulus
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        clear_model();
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (4) @(posedge clk);
        for (int r = 1; r < 8; r++) begin
            send_instr(encode(op_addi, r, 0, 0, rand_below(256)));
        end
        for (int a = 0; a < 8; a++) begin
            send_instr(encode(op_st, 0, 0, 1 + a % 7, a));
        end
        // load-use, then back-to-back dependents
        send_instr(encode(op_ld, 3, 0, 0, 2));
        send_instr(encode(op_add, 4, 3, 3, 0));
        send_instr(encode(op_sub, 5, 4, 3, 0));
        send_instr(encode(op_addi, 5, 5, 0, -3));
        send_instr(encode(op_mul, 6, 4, 5, 0));
        send_instr(encode(op_mul, 7, 6, 6, 0));
        send_instr(encode(op_xor, 1, 7, 6, 0));
        // product stored, reloaded and stored again
        send_instr(encode(op_st, 0, 0, 7, 5));
        send_instr(encode(op_ld, 2, 0, 0, 5));
        send_instr(encode(op_st, 0, 0, 2, 6));
        // no beat for these
        send_instr(encode(op_ld, 0, 0, 0, 6));
        send_instr(encode(op_add, 0, 1, 2, 0));
        send_instr(encode(op_nop, 0, 0, 0, 0));
        while (sent < n_instr) begin
            send_instr(random_instr());
        end
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        while (exp_have || credits_back != sent) begin
            @(posedge clk);
            #1;
        end
        // trailing stores and nops leave the pipe
        repeat (mul_cycles + 4) @(posedge clk);
        #1;
        if (credits_back == sent && !exp_have && sent == n_instr) begin
            $display("Test completed successfully");
            $finish;
        end
        else begin
            stop_with_failure("credits or results left over at the end of the run");
        end
    end

endmodule

// ==== verilog/core_pkg.sv ====
package core_pkg;

    localparam int data_w     = 16;
    localparam int reg_addr_w = 3;
    localparam int imm_w      = 8;

    typedef enum logic [3:0] {
        op_nop,
        op_add,
        op_sub,
        op_and,
        op_xor,
        op_addi,
        op_mul,
        op_ld,
        op_st
    } opcode_e;

    // 21-bit instruction word
    typedef struct packed {
        opcode_e                opcode;
        logic [reg_addr_w-1:0]  rd;
        logic [reg_addr_w-1:0]  rs;
        logic [reg_addr_w-1:0]  rt;
        logic [imm_w-1:0]       imm;
    } instr_t;

    typedef enum logic [1:0] {
        mem_none,
        mem_load,
        mem_store
    } mem_kind_e;

    typedef struct packed {
        logic                   valid;
        opcode_e                opcode;
        logic [reg_addr_w-1:0]  rd;
        logic [reg_addr_w-1:0]  rs;
        logic [reg_addr_w-1:0]  rt;
        logic [data_w-1:0]      op_a;
        logic [data_w-1:0]      op_b;
        logic [data_w-1:0]      imm;
    } dec_payload_t;

    // result holds the address for loads and stores
    typedef struct packed {
        logic                   valid;
        mem_kind_e              kind;
        logic [reg_addr_w-1:0]  rd;
        logic [data_w-1:0]      result;
        logic [data_w-1:0]      store_data;
    } exe_payload_t;

endpackage

// ==== verilog/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage
    import core_pkg::*;
#(
    parameter int in_credits = 2
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    instr_valid,
    input  instr_t                  instr,
    output logic                    instr_credit,
    output logic [reg_addr_w-1:0]   raddr_a,
    output logic [reg_addr_w-1:0]   raddr_b,
    input  logic [data_w-1:0]       rdata_a,
    input  logic [data_w-1:0]       rdata_b,
    hazard_if.decode                hz,
    output dec_payload_t            dec_out
);

    localparam int aw = (in_credits > 1) ? $clog2(in_credits) : 1;
    localparam int cw = $clog2(in_credits + 1);

    instr_t         skid [in_credits];
    logic [aw-1:0]  wr_ptr;
    logic [aw-1:0]  rd_ptr;
    logic [cw-1:0]  count;
    logic           empty;
    logic           pop;
    instr_t         head;
    dec_payload_t   dec_next;

    assign empty = (count == '0);
    assign pop   = hz.en_dec && !empty;
    assign head  = skid[rd_ptr];

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            skid[wr_ptr] <= instr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            instr_credit <= 1'b0;
        end
        else begin
            if (instr_valid) begin
                wr_ptr <= (wr_ptr == aw'(in_credits - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == aw'(in_credits - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count        <= count + cw'(instr_valid) - cw'(pop);
            instr_credit <= pop;
        end
    end

    assign raddr_a   = head.rs;
    assign raddr_b   = head.rt;
    assign hz.dec_rs = empty ? '0 : head.rs;
    assign hz.dec_rt = empty ? '0 : head.rt;

    always_comb begin
        dec_next.valid  = !empty;
        dec_next.opcode = head.opcode;
        dec_next.rd     = head.rd;
        dec_next.rs     = head.rs;
        dec_next.rt     = head.rt;
        dec_next.op_a   = rdata_a;
        dec_next.op_b   = rdata_b;
        dec_next.imm    = {{(data_w - imm_w){head.imm[imm_w-1]}}, head.imm};
    end

    always_ff @(posedge clk) begin
        if (rst || hz.bubble_exe) begin
            dec_out.valid <= 1'b0;
        end
        else if (hz.en_dec) begin
            dec_out <= dec_next;
        end
    end

    // source must stay within its credits
    a_skid_no_overflow: assert property (
        @(posedge clk) disable iff (rst)
        instr_valid |-> (count != cw'(in_credits))
    ) else $error("instruction arrived with skid buffer full");

endmodule

// ==== verilog/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage
    import core_pkg::*;
#(
    parameter int mul_cycles = 4
) (
    input  logic                    clk,
    input  logic                    rst,
    input  dec_payload_t            dec_in,
    input  logic                    fwd_valid,
    input  logic [reg_addr_w-1:0]   fwd_rd,
    input  logic [data_w-1:0]       fwd_data,
    hazard_if.execute               hz,
    output exe_payload_t            exe_out
);

    localparam int mcw = (mul_cycles > 1) ? $clog2(mul_cycles) : 1;

    logic [data_w-1:0]      op_a;
    logic [data_w-1:0]      op_b;
    logic                   own_ok;
    logic [2*data_w-1:0]    prod_full;
    logic [data_w-1:0]      prod_q;
    logic [data_w-1:0]      mul_res;
    logic [mcw-1:0]         mul_cnt;
    logic                   mul_busy;
    exe_payload_t           exe_next;

    assign own_ok = exe_out.valid && exe_out.kind == mem_none && exe_out.rd != '0;

    // own register beats result forward beats decoded value
    always_comb begin
        op_a = dec_in.op_a;
        op_b = dec_in.op_b;
        if (fwd_valid && fwd_rd == dec_in.rs) op_a = fwd_data;
        if (fwd_valid && fwd_rd == dec_in.rt) op_b = fwd_data;
        if (own_ok && exe_out.rd == dec_in.rs) op_a = exe_out.result;
        if (own_ok && exe_out.rd == dec_in.rt) op_b = exe_out.result;
    end

    // operands are sampled on the first multiply cycle, forwards may drain after
    assign prod_full = op_a * op_b;
    assign mul_res   = (mul_cnt == '0) ? prod_full[data_w-1:0] : prod_q;
    assign mul_busy  = dec_in.valid && dec_in.opcode == op_mul &&
                       mul_cnt != mcw'(mul_cycles - 1);

    always_ff @(posedge clk) begin
        if (rst || hz.en_exe) mul_cnt <= '0;
        else if (mul_busy) mul_cnt <= mul_cnt + 1'b1;
    end

    always_ff @(posedge clk) begin
        if (mul_busy && mul_cnt == '0) prod_q <= prod_full[data_w-1:0];
    end

    always_comb begin
        exe_next.valid      = dec_in.valid;
        exe_next.kind       = mem_none;
        exe_next.rd         = dec_in.rd;
        exe_next.result     = '0;
        exe_next.store_data = op_b;
        case (dec_in.opcode)
            op_add:  exe_next.result = op_a + op_b;
            op_sub:  exe_next.result = op_a - op_b;
            op_and:  exe_next.result = op_a & op_b;
            op_xor:  exe_next.result = op_a ^ op_b;
            op_addi: exe_next.result = op_a + dec_in.imm;
            op_mul:  exe_next.result = mul_res;
            op_ld: begin
                exe_next.kind   = mem_load;
                exe_next.result = op_a + dec_in.imm;
            end
            op_st: begin
                exe_next.kind   = mem_store;
                exe_next.rd     = '0;
                exe_next.result = op_a + dec_in.imm;
            end
            default: exe_next.rd = '0;
        endcase
    end

    assign hz.ex_stall = mul_busy;
    assign hz.exe_kind = dec_in.valid ? exe_next.kind : mem_none;
    assign hz.exe_rd   = exe_next.rd;

    always_ff @(posedge clk) begin
        if (rst) exe_out.valid <= 1'b0;
        else if (hz.en_exe) exe_out <= exe_next;
        else if (hz.en_res) exe_out.valid <= 1'b0;
    end

    a_mul_bounded: assert property (
        @(posedge clk) disable iff (rst)
        $rose(hz.ex_stall) |-> ##[1:mul_cycles] !hz.ex_stall
    ) else $error("multiply stall exceeded mul_cycles");

endmodule

// ==== verilog/hazard_if.sv ====
`timescale 1ns/1ps

interface hazard_if
    import core_pkg::*;
(
    input logic clk
);

    logic                   ex_stall;
    logic                   mem_stall;
    mem_kind_e              exe_kind;
    logic [reg_addr_w-1:0]  exe_rd;
    logic [reg_addr_w-1:0]  dec_rs;
    logic [reg_addr_w-1:0]  dec_rt;

    logic                   en_dec;
    logic                   en_exe;
    logic                   en_res;
    logic                   bubble_exe;

    modport decode (output dec_rs, dec_rt, input en_dec, bubble_exe);
    modport execute (output ex_stall, exe_kind, exe_rd, input en_exe, en_res);
    modport result (output mem_stall, input en_res);
    modport ctrl (
        input  clk, ex_stall, mem_stall, exe_kind, exe_rd, dec_rs, dec_rt,
        output en_dec, en_exe, en_res, bubble_exe
    );

endinterface

// ==== verilog/mini_core.sv ====
`timescale 1ns/1ps

module mini_core
    import core_pkg::*;
#(
    parameter int in_credits  = 2,
    parameter int out_credits = 4,
    parameter int mul_cycles  = 4,
    parameter int dmem_depth  = 64
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    instr_valid,
    input  instr_t                  instr,
    output logic                    instr_credit,
    output logic                    res_valid,
    output logic [reg_addr_w-1:0]   res_rd,
    output logic [data_w-1:0]       res_data,
    input  logic                    res_credit
);

    logic [reg_addr_w-1:0]  raddr_a;
    logic [reg_addr_w-1:0]  raddr_b;
    logic [data_w-1:0]      rdata_a;
    logic [data_w-1:0]      rdata_b;
    logic                   we;
    logic [reg_addr_w-1:0]  waddr;
    logic [data_w-1:0]      wdata;
    logic                   fwd_valid;
    logic [reg_addr_w-1:0]  fwd_rd;
    logic [data_w-1:0]      fwd_data;
    dec_payload_t           dec_pl;
    exe_payload_t           exe_pl;

    hazard_if hz_i (.clk(clk));

    pipe_ctrl ctrl_i (.rst(rst), .hz(hz_i.ctrl));

    reg_file rf_i (
        .clk(clk), .rst(rst),
        .raddr_a(raddr_a), .raddr_b(raddr_b),
        .rdata_a(rdata_a), .rdata_b(rdata_b),
        .we(we), .waddr(waddr), .wdata(wdata)
    );

    decode_stage #(.in_credits(in_credits)) dec_i (
        .clk(clk), .rst(rst),
        .instr_valid(instr_valid), .instr(instr), .instr_credit(instr_credit),
        .raddr_a(raddr_a), .raddr_b(raddr_b),
        .rdata_a(rdata_a), .rdata_b(rdata_b),
        .hz(hz_i.decode), .dec_out(dec_pl)
    );

    execute_stage #(.mul_cycles(mul_cycles)) exe_i (
        .clk(clk), .rst(rst), .dec_in(dec_pl),
        .fwd_valid(fwd_valid), .fwd_rd(fwd_rd), .fwd_data(fwd_data),
        .hz(hz_i.execute), .exe_out(exe_pl)
    );

    result_stage #(.out_credits(out_credits), .dmem_depth(dmem_depth)) res_i (
        .clk(clk), .rst(rst), .exe_in(exe_pl), .hz(hz_i.result),
        .we(we), .waddr(waddr), .wdata(wdata),
        .fwd_valid(fwd_valid), .fwd_rd(fwd_rd), .fwd_data(fwd_data),
        .res_valid(res_valid), .res_rd(res_rd), .res_data(res_data),
        .res_credit(res_credit)
    );

endmodule

// ==== verilog/pipe_ctrl.sv ====
`timescale 1ns/1ps

module pipe_ctrl
    import core_pkg::*;
(
    input logic     rst,
    hazard_if.ctrl  hz
);

    logic [2:0] en;
    logic       bubble;
    logic       load_use;

    assign {hz.en_dec, hz.en_exe, hz.en_res} = en;
    assign hz.bubble_exe = bubble;

    // load in execute feeding the instruction now in decode
    assign load_use = (hz.exe_kind == mem_load) && (hz.exe_rd != '0) &&
                      ((hz.exe_rd == hz.dec_rs) || (hz.exe_rd == hz.dec_rt));

    always_comb begin : stall_priority
        bubble = 1'b0;
        if (rst) begin
            en = 3'b111;
        end
        else if (hz.mem_stall) begin
            en = 3'b000;
        end
        else if (hz.ex_stall) begin
            // result stage drains behind the multiply
            en = 3'b001;
        end
        else if (load_use) begin
            en     = 3'b011;
            bubble = 1'b1;
        end
        else begin
            en = 3'b111;
        end
    end

    // the load moves on behind the bubble, so the hazard clears next cycle
    a_bubble_once: assert property (
        @(posedge hz.clk) disable iff (rst)
        hz.bubble_exe |=> !hz.bubble_exe
    ) else $error("load-use bubble held for more than one cycle");

endmodule

// ==== verilog/reg_file.sv ====
`timescale 1ns/1ps

module reg_file
    import core_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic [reg_addr_w-1:0]   raddr_a,
    input  logic [reg_addr_w-1:0]   raddr_b,
    output logic [data_w-1:0]       rdata_a,
    output logic [data_w-1:0]       rdata_b,
    input  logic                    we,
    input  logic [reg_addr_w-1:0]   waddr,
    input  logic [data_w-1:0]       wdata
);

    logic [data_w-1:0] regs [1 << reg_addr_w];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < (1 << reg_addr_w); i++) begin
                regs[i] <= '0;
            end
        end
        else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // write-first so decode sees same-cycle write-back
    assign rdata_a = (raddr_a == '0) ? '0 :
                     (we && waddr == raddr_a) ? wdata : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 :
                     (we && waddr == raddr_b) ? wdata : regs[raddr_b];

endmodule

// ==== verilog/result_stage.sv ====
`timescale 1ns/1ps

module result_stage
    import core_pkg::*;
#(
    parameter int out_credits = 4,
    parameter int dmem_depth  = 64
) (
    input  logic                    clk,
    input  logic                    rst,
    input  exe_payload_t            exe_in,
    hazard_if.result                hz,
    output logic                    we,
    output logic [reg_addr_w-1:0]   waddr,
    output logic [data_w-1:0]       wdata,
    output logic                    fwd_valid,
    output logic [reg_addr_w-1:0]   fwd_rd,
    output logic [data_w-1:0]       fwd_data,
    output logic                    res_valid,
    output logic [reg_addr_w-1:0]   res_rd,
    output logic [data_w-1:0]       res_data,
    input  logic                    res_credit
);

    localparam int aw = $clog2(dmem_depth);
    localparam int cw = $clog2(out_credits + 1);

    logic [data_w-1:0]  dmem [dmem_depth];
    logic [data_w-1:0]  addr_mod;
    logic [aw-1:0]      mem_idx;
    logic [data_w-1:0]  rd_s1;
    logic [data_w-1:0]  rd_s2;
    logic [1:0]         ld_cnt;
    logic               is_load;
    logic               ld_pend;
    logic               wb_ok;
    logic [data_w-1:0]  wb_data;
    logic [cw-1:0]      credit_cnt;

    assign addr_mod = exe_in.result % data_w'(dmem_depth);
    assign mem_idx  = addr_mod[aw-1:0];

    always_ff @(posedge clk) begin
        if (exe_in.valid && exe_in.kind == mem_store && hz.en_res) begin
            dmem[mem_idx] <= exe_in.store_data;
        end
        rd_s1 <= dmem[mem_idx];
        rd_s2 <= rd_s1;
    end

    // load data shows up in rd_s2 two cycles after arrival
    assign is_load = exe_in.valid && exe_in.kind == mem_load;
    assign ld_pend = is_load && ld_cnt != 2'd2;

    always_ff @(posedge clk) begin
        if (rst || hz.en_res) ld_cnt <= '0;
        else if (ld_pend) ld_cnt <= ld_cnt + 1'b1;
    end

    assign wb_ok   = exe_in.valid && exe_in.kind != mem_store && exe_in.rd != '0 && !ld_pend;
    assign wb_data = is_load ? rd_s2 : exe_in.result;

    assign res_valid    = wb_ok && credit_cnt != '0;
    assign res_rd       = exe_in.rd;
    assign res_data     = wb_data;
    assign hz.mem_stall = ld_pend || (wb_ok && credit_cnt == '0);

    assign we        = res_valid;
    assign waddr     = exe_in.rd;
    assign wdata     = wb_data;
    assign fwd_valid = wb_ok;
    assign fwd_rd    = exe_in.rd;
    assign fwd_data  = wb_data;

    always_ff @(posedge clk) begin
        if (rst) credit_cnt <= cw'(out_credits);
        else credit_cnt <= credit_cnt + cw'(res_credit) - cw'(res_valid);
    end

    // consumer never returns more than it was given
    a_credit_ok: assert property (
        @(posedge clk) disable iff (rst)
        credit_cnt <= cw'(out_credits)
    ) else $error("result credit count above out_credits");

endmodule
